// ==== logic/exec_pkg.sv ====
/*
 * Shared widths and encodings for the execute stage
 * Functional unit select, micro-op enums, branch outcome codes
 */
package exec_pkg;

// Widths
// ----------------------------------------

localparam int XLEN       = 32;                 // Operand width
localparam int REG_ADDR_W = 5;                  // Register address
localparam int UOP_W      = 5;                  // Micro-op field
localparam int FU_W       = 3;                  // Functional unit select
localparam int SIZE_W     = 2;                  // Instruction size field
localparam int INSTR_W    = 32;                 // Instruction word

localparam int MUL_STEPS  = XLEN;               // One step per multiplier bit
localparam int MUL_CNT_W  = $clog2(MUL_STEPS) + 1;

// rd, opr_a, opr_b, uop, fu, trap, size, instr
localparam int PIPE_W = REG_ADDR_W + 2 * XLEN + UOP_W + FU_W + 1 + SIZE_W + INSTR_W;

// Encodings
// ----------------------------------------

typedef logic [UOP_W-1:0] uop_t;                // Micro-op as carried on ports

typedef enum logic [FU_W-1:0] {
    FU_ALU = 3'd0,                              // Integer ALU
    FU_MUL = 3'd1,                              // Iterative multiplier
    FU_LSU = 3'd2,                              // Load/store address gen
    FU_CFU = 3'd3,                              // Branches and jumps
    FU_CSR = 3'd4                               // CSR access
} exec_fu_e;

typedef enum logic [UOP_W-1:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,                            // Signed compare
    ALU_SLTU = 5'd9                             // Unsigned compare
} alu_op_e;

typedef enum logic [UOP_W-1:0] {
    MUL_MUL   = 5'd0,                           // Low half of unsigned product
    MUL_MULHU = 5'd1                            // High half
} mul_op_e;

typedef enum logic [UOP_W-1:0] {
    LSU_LOAD  = 5'd0,
    LSU_STORE = 5'd1
} lsu_op_e;

typedef enum logic [UOP_W-1:0] {
    CFU_BEQ       = 5'd0,
    CFU_BNE       = 5'd1,
    CFU_BLT       = 5'd2,
    CFU_BGE       = 5'd3,
    CFU_BLTU      = 5'd4,
    CFU_BGEU      = 5'd5,
    CFU_JAL       = 5'd6,
    CFU_JALR      = 5'd7,
    CFU_TAKEN     = 5'd8,                       // Outcome codes, s3 side only
    CFU_NOT_TAKEN = 5'd9
} cfu_op_e;

endpackage

// ==== logic/exec_alu.sv ====
/*
 * Combinational integer ALU
 * Logic ops, add/sub, shifts, set-less-than, compare flags
 */
`timescale 1ns/100ps

module exec_alu import exec_pkg::*; (
    input  alu_op_e           i_op,             // Operation select
    input  logic [XLEN-1:0]   i_lhs,            // Left operand
    input  logic [XLEN-1:0]   i_rhs,            // Right operand
    output logic [XLEN-1:0]   o_result,         // Selected result
    output logic [XLEN-1:0]   o_add_result,     // Raw sum for address / jalr
    output logic              o_lt,             // lhs < rhs, signedness per op
    output logic              o_eq              // lhs == rhs
);

logic [XLEN-1:0] sum;                           // lhs + rhs
logic [XLEN-1:0] diff;                          // lhs - rhs
logic [4:0]      shamt;                         // Low shift bits
logic            lt_signed;
logic            lt_unsigned;
logic            use_unsigned;

// Arithmetic and compare
// ----------------------------------------

assign sum          = i_lhs + i_rhs;
assign diff         = i_lhs - i_rhs;
assign shamt        = i_rhs[4:0];

assign lt_signed    = $signed(i_lhs) < $signed(i_rhs);
assign lt_unsigned  = i_lhs < i_rhs;
assign use_unsigned = i_op == ALU_SLTU;         // Everything else compares signed

assign o_lt         = use_unsigned ? lt_unsigned : lt_signed;
assign o_eq         = i_lhs == i_rhs;
assign o_add_result = sum;                      // Always the sum

// Result mux
// ----------------------------------------

always_comb begin
    case (i_op)
        ALU_ADD:  o_result = sum;
        ALU_SUB:  o_result = diff;
        ALU_XOR:  o_result = i_lhs ^ i_rhs;
        ALU_OR:   o_result = i_lhs | i_rhs;
        ALU_AND:  o_result = i_lhs & i_rhs;
        ALU_SLL:  o_result = i_lhs << shamt;
        ALU_SRL:  o_result = i_lhs >> shamt;
        ALU_SRA:  o_result = XLEN'($signed(i_lhs) >>> shamt); // Sign fill
        ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_signed};
        ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
        default:  o_result = '0;                // Unused encodings
    endcase
end

endmodule

// ==== logic/exec_multiplier.sv ====
/*
 * Iterative shift-add multiplier, unsigned 32x32 to 64
 * IDLE/RUN/DONE control with step counter, result held until clear
 */
`timescale 1ns/100ps

module exec_multiplier import exec_pkg::*; (
    input  logic                g_clk,          // Core clock
    input  logic                i_reset,        // Sync reset, active high
    input  logic                i_valid,        // Multiply presented
    input  logic                i_clear,        // Progress or flush, back to idle
    input  logic [XLEN-1:0]     i_rs1,          // Multiplicand
    input  logic [XLEN-1:0]     i_rs2,          // Multiplier
    output logic [2*XLEN-1:0]   o_product,      // Full unsigned product
    output logic                o_done          // Product valid
);

typedef enum logic [1:0] {
    IDLE,                                       // Waiting for a multiply
    RUN,                                        // Stepping through rs2 bits
    DONE                                        // Result held
} mul_state_e;

mul_state_e            state;
logic [MUL_CNT_W-1:0]  count;                   // Steps taken in RUN
logic [2*XLEN-1:0]     acc;                     // Partial product sum
logic [2*XLEN-1:0]     mcand;                   // Shifted multiplicand
logic [XLEN-1:0]       mplr;                    // Remaining multiplier bits
logic                  last_step;

assign last_step = count == MUL_CNT_W'(MUL_STEPS - 1);

// Control
// ----------------------------------------

always_ff @(posedge g_clk) begin
    if (i_reset || i_clear) begin
        state <= IDLE;
        count <= '0;
    end else begin
        case (state)
            IDLE: if (i_valid) begin            // Start on first valid cycle
                state <= RUN;
                count <= '0;
            end
            RUN: begin
                count <= count + 1'b1;
                if (last_step) begin
                    state <= DONE;              // 32 steps complete
                end
            end
            default: state <= state;            // Hold in DONE until clear
        endcase
    end
end

// Shift-add datapath
// ----------------------------------------

always_ff @(posedge g_clk) begin
    if (state == IDLE) begin
        acc   <= '0;                            // Operands sampled while idle
        mcand <= {{XLEN{1'b0}}, i_rs1};
        mplr  <= i_rs2;
    end else if (state == RUN) begin
        if (mplr[0]) begin
            acc <= acc + mcand;                 // Add on set bit
        end
        mcand <= mcand << 1;
        mplr  <= mplr >> 1;
    end
end

assign o_product = acc;
assign o_done    = state == DONE;

a_mul_count: assert property (@(posedge g_clk) disable iff (i_reset)
    state == RUN |-> count < MUL_CNT_W'(MUL_STEPS))
    else $error("Multiplier step count out of range");

// Finished product matches the operands still held at the input
a_mul_done: assert property (@(posedge g_clk) disable iff (i_reset)
    $rose(o_done) && i_valid |->
        o_product == {{XLEN{1'b0}}, i_rs1} * {{XLEN{1'b0}}, i_rs2})
    else $error("Multiplier product does not match operands");

endmodule

// ==== logic/exec_result_select.sv ====
/*
 * Per-unit result forming for the execute pipeline register
 * Branch outcome, jump targets, LSU address, CSR pass-through, trap cause
 */
`timescale 1ns/100ps

module exec_result_select import exec_pkg::*; (
    input  exec_fu_e            i_fu,           // Functional unit
    input  uop_t                i_uop,          // Micro-op from decode
    input  logic [REG_ADDR_W-1:0] i_rd,         // Dest reg, trap cause on trap
    input  logic                i_trap,         // Trapped instruction
    input  logic [XLEN-1:0]     i_opr_a,        // CSR operand
    input  logic [XLEN-1:0]     i_opr_c,        // Branch target / store data / CSR
    input  logic [XLEN-1:0]     i_alu_result,
    input  logic [XLEN-1:0]     i_add_result,   // Address and jalr sum
    input  logic                i_lt,
    input  logic                i_eq,
    input  logic [2*XLEN-1:0]   i_product,
    output logic [XLEN-1:0]     o_opr_a,        // To s3 operand A
    output logic [XLEN-1:0]     o_opr_b,        // To s3 operand B
    output uop_t                o_uop           // Rewritten for branches
);

cfu_op_e          cfu_op;
mul_op_e          mul_op;
logic             cfu_cond;                     // Conditional branch
logic             cfu_jalr;
logic             taken;
logic [XLEN-1:0]  mul_half;                     // Half picked by uop

assign cfu_op   = cfu_op_e'(i_uop);
assign mul_op   = mul_op_e'(i_uop);
assign cfu_cond = i_fu == FU_CFU &&
                  cfu_op inside {CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU};
assign cfu_jalr = cfu_op == CFU_JALR;
assign mul_half = mul_op == MUL_MULHU ? i_product[2*XLEN-1:XLEN] : i_product[XLEN-1:0];

// Branch decision
// ----------------------------------------

always_comb begin
    case (cfu_op)
        CFU_BEQ:            taken = i_eq;
        CFU_BNE:            taken = !i_eq;
        CFU_BLT, CFU_BLTU:  taken = i_lt;       // ALU picked signedness
        CFU_BGE, CFU_BGEU:  taken = !i_lt;
        default:            taken = 1'b0;
    endcase
end

assign o_uop = cfu_cond ? (taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop;

// Operand forming
// ----------------------------------------

always_comb begin
    case (i_fu)
        FU_ALU:  o_opr_a = i_alu_result;
        FU_MUL:  o_opr_a = mul_half;
        FU_LSU:  o_opr_a = i_add_result;        // Effective address
        FU_CFU:  o_opr_a = cfu_jalr ? {i_add_result[XLEN-1:1], 1'b0}
                                    : {i_opr_c[XLEN-1:1], 1'b0};
        FU_CSR:  o_opr_a = i_opr_a;
        default: o_opr_a = '0;
    endcase
end

always_comb begin
    if (i_trap) begin
        o_opr_b = XLEN'(i_rd);                  // Cause rides in rd
    end else begin
        case (i_fu)
            FU_MUL:         o_opr_b = i_product[2*XLEN-1:XLEN];
            FU_LSU, FU_CSR: o_opr_b = i_opr_c;  // Store data / CSR data
            default:        o_opr_b = '0;       // ALU and branches
        endcase
    end
end

endmodule

// ==== logic/exec_pipe_reg.sv ====
/*
 * Single-entry valid/busy pipeline register with flush
 */
`timescale 1ns/100ps

module exec_pipe_reg import exec_pkg::*; (
    input  logic                g_clk,          // Core clock
    input  logic                i_reset,        // Sync reset, active high
    input  logic                i_flush,        // Drop held item
    input  logic                i_valid,        // New item offered
    input  logic [PIPE_W-1:0]   i_data,
    output logic                o_busy,         // Held item is blocked
    output logic                o_valid,        // Item available downstream
    output logic [PIPE_W-1:0]   o_data,
    input  logic                i_busy          // Downstream stalled
);

logic load;                                     // Take a new item this edge

assign o_busy = o_valid && i_busy;
assign load   = i_valid && !o_busy;

// Valid bit
// ----------------------------------------

always_ff @(posedge g_clk) begin
    if (i_reset || i_flush) begin
        o_valid <= 1'b0;
    end else if (load) begin
        o_valid <= 1'b1;
    end else if (!i_busy) begin
        o_valid <= 1'b0;                        // Consumed, nothing behind it
    end
end

// Payload
always_ff @(posedge g_clk) begin
    if (load) begin
        o_data <= i_data;
    end
end

// Blocked item must not change under back-pressure
a_pipe_hold: assert property (@(posedge g_clk) disable iff (i_reset)
    o_valid && i_busy |=> $stable(o_data))
    else $error("Pipeline payload changed while stalled");

endmodule

// ==== logic/exec_stage.sv ====
/*
 * Execute stage top level
 * Unit instances, ALU op choice, stall and progress, forwarding, s3 register
 */
`timescale 1ns/100ps

module exec_stage import exec_pkg::*; (
    input  logic                    g_clk,      // Core clock
    input  logic                    i_reset,    // Sync reset, active high
    input  logic                    i_flush,    // Kill stage contents
    input  logic                    i_s2_valid,
    input  logic [REG_ADDR_W-1:0]   i_s2_rd,
    input  logic [XLEN-1:0]         i_s2_opr_a,
    input  logic [XLEN-1:0]         i_s2_opr_b,
    input  logic [XLEN-1:0]         i_s2_opr_c,
    input  uop_t                    i_s2_uop,
    input  exec_fu_e                i_s2_fu,
    input  logic                    i_s2_trap,
    input  logic [SIZE_W-1:0]       i_s2_size,
    input  logic [INSTR_W-1:0]      i_s2_instr,
    output logic                    o_s2_busy,  // Decode must hold inputs
    output logic [REG_ADDR_W-1:0]   o_fwd_rd,
    output logic [XLEN-1:0]         o_fwd_wdata,
    output logic                    o_fwd_load,
    output logic                    o_fwd_csr,
    output logic                    o_s3_valid,
    output logic [REG_ADDR_W-1:0]   o_s3_rd,
    output logic [XLEN-1:0]         o_s3_opr_a,
    output logic [XLEN-1:0]         o_s3_opr_b,
    output uop_t                    o_s3_uop,
    output exec_fu_e                o_s3_fu,
    output logic                    o_s3_trap,
    output logic [SIZE_W-1:0]       o_s3_size,
    output logic [INSTR_W-1:0]      o_s3_instr,
    input  logic                    i_s3_busy   // Writeback stalled
);

logic               fu_alu, fu_mul;
alu_op_e            alu_op;
logic [XLEN-1:0]    alu_result, alu_add_result;
logic               alu_lt, alu_eq;
logic [2*XLEN-1:0]  mul_product;
logic               mul_done;
logic [XLEN-1:0]    n_opr_a, n_opr_b;           // Next s3 operands
uop_t               n_uop;
logic               p_busy;                     // s3 register blocked
logic               pipe_progress;              // Instruction accepted
logic [PIPE_W-1:0]  pipe_in, pipe_out;
logic [FU_W-1:0]    s3_fu_raw;

assign fu_alu = i_s2_fu == FU_ALU;
assign fu_mul = i_s2_fu == FU_MUL;

// ALU op choice
// ----------------------------------------

always_comb begin
    case (i_s2_fu)
        FU_ALU: alu_op = alu_op_e'(i_s2_uop);
        FU_CFU: begin
            if (cfu_op_e'(i_s2_uop) == CFU_JALR) begin
                alu_op = ALU_ADD;               // Jump target sum
            end else if (cfu_op_e'(i_s2_uop) inside {CFU_BLTU, CFU_BGEU}) begin
                alu_op = ALU_SLTU;
            end else begin
                alu_op = ALU_SLT;
            end
        end
        default: alu_op = ALU_ADD;              // LSU address and the rest
    endcase
end

// Stall and progress
assign o_s2_busy     = p_busy || (i_s2_valid && fu_mul && !mul_done);
assign pipe_progress = i_s2_valid && !o_s2_busy;

exec_alu u_alu (
    .i_op(alu_op), .i_lhs(i_s2_opr_a), .i_rhs(i_s2_opr_b),
    .o_result(alu_result), .o_add_result(alu_add_result),
    .o_lt(alu_lt), .o_eq(alu_eq)
);

exec_multiplier u_mul (
    .g_clk(g_clk), .i_reset(i_reset),
    .i_valid(i_s2_valid && fu_mul), .i_clear(pipe_progress || i_flush),
    .i_rs1(i_s2_opr_a), .i_rs2(i_s2_opr_b),
    .o_product(mul_product), .o_done(mul_done)
);

exec_result_select u_sel (
    .i_fu(i_s2_fu), .i_uop(i_s2_uop), .i_rd(i_s2_rd), .i_trap(i_s2_trap),
    .i_opr_a(i_s2_opr_a), .i_opr_c(i_s2_opr_c),
    .i_alu_result(alu_result), .i_add_result(alu_add_result),
    .i_lt(alu_lt), .i_eq(alu_eq), .i_product(mul_product),
    .o_opr_a(n_opr_a), .o_opr_b(n_opr_b), .o_uop(n_uop)
);

// Forwarding, straight from s2
assign o_fwd_rd    = i_s2_rd;
assign o_fwd_wdata = (fu_alu || fu_mul) ? n_opr_a : '0;  // Operand A holds the result
assign o_fwd_load  = i_s2_fu == FU_LSU && lsu_op_e'(i_s2_uop) == LSU_LOAD;
assign o_fwd_csr   = i_s2_fu == FU_CSR;

// s3 register
// ----------------------------------------

assign pipe_in = {i_s2_rd, n_opr_a, n_opr_b, n_uop, i_s2_fu,
                  i_s2_trap, i_s2_size, i_s2_instr};

exec_pipe_reg u_pipe (
    .g_clk(g_clk), .i_reset(i_reset), .i_flush(i_flush),
    .i_valid(pipe_progress), .i_data(pipe_in), .o_busy(p_busy),
    .o_valid(o_s3_valid), .o_data(pipe_out), .i_busy(i_s3_busy)
);

assign {o_s3_rd, o_s3_opr_a, o_s3_opr_b, o_s3_uop, s3_fu_raw,
        o_s3_trap, o_s3_size, o_s3_instr} = pipe_out;
assign o_s3_fu = exec_fu_e'(s3_fu_raw);

a_fu_legal: assert property (@(posedge g_clk) disable iff (i_reset)
    i_s2_valid |-> i_s2_fu inside {FU_ALU, FU_MUL, FU_LSU, FU_CFU, FU_CSR})
    else $error("Illegal functional unit select");

endmodule

// ==== test/tb_exec_stage.sv ====
/*
 * Testbench for the execute stage
 * Case file stimulus, random writeback stall, in-order result checks, flush
 */
`timescale 1ns/100ps

module tb_exec_stage import exec_pkg::*; ();

localparam int MAX_CASES    = 64;
localparam int CASE_WORDS   = 10;               // Hex words per case line
localparam int CASE_TIMEOUT = 200;              // Cycles allowed per wait loop

logic                   g_clk;
logic                   i_reset;
logic                   i_flush;
logic                   i_s2_valid;
logic [REG_ADDR_W-1:0]  i_s2_rd;
logic [XLEN-1:0]        i_s2_opr_a;
logic [XLEN-1:0]        i_s2_opr_b;
logic [XLEN-1:0]        i_s2_opr_c;
uop_t                   i_s2_uop;
exec_fu_e               i_s2_fu;
logic                   i_s2_trap;
logic [SIZE_W-1:0]      i_s2_size;
logic [INSTR_W-1:0]     i_s2_instr;
logic                   o_s2_busy;
logic [REG_ADDR_W-1:0]  o_fwd_rd;
logic [XLEN-1:0]        o_fwd_wdata;
logic                   o_fwd_load;
logic                   o_fwd_csr;
logic                   o_s3_valid;
logic [REG_ADDR_W-1:0]  o_s3_rd;
logic [XLEN-1:0]        o_s3_opr_a;
logic [XLEN-1:0]        o_s3_opr_b;
uop_t                   o_s3_uop;
exec_fu_e               o_s3_fu;
logic                   o_s3_trap;
logic [SIZE_W-1:0]      o_s3_size;
logic [INSTR_W-1:0]     o_s3_instr;
logic                   i_s3_busy;

logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1]; // fu uop a b c rd trap exp_a exp_b exp_uop
int          exp_q[$];                          // Case indices in flight, oldest first
int          num_cases;
int          idx;
int          j;
int          waited;
int          seed;
logic        first_cycle;                       // Case just put on the input

exec_stage exec_stage_i (.*);

initial begin
    g_clk = 1'b0;
    forever begin
        #4 g_clk = ~g_clk;                      // 8 ns period
    end
end

function automatic logic [31:0] case_word(input int n, input int col);
    case_word = case_mem[n*CASE_WORDS + col];
endfunction

// Forwarded write data is only defined for ALU and multiply results
function automatic logic [31:0] expected_wdata(input int n);
    if (case_word(n, 0) == FU_ALU || case_word(n, 0) == FU_MUL) begin
        expected_wdata = case_word(n, 7);
    end else begin
        expected_wdata = '0;
    end
endfunction

task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic drive_case(input int n);
    i_s2_valid = 1'b1;
    i_s2_fu    = exec_fu_e'(FU_W'(case_word(n, 0)));
    i_s2_uop   = UOP_W'(case_word(n, 1));
    i_s2_opr_a = case_word(n, 2);
    i_s2_opr_b = case_word(n, 3);
    i_s2_opr_c = case_word(n, 4);
    i_s2_rd    = REG_ADDR_W'(case_word(n, 5));
    i_s2_trap  = case_word(n, 6) != 0;
    i_s2_size  = SIZE_W'(n);                    // Tags the case on the way through
    i_s2_instr = {16'h00c0, n[15:0]};
endtask

// Oldest outstanding case must be the one leaving s3
task automatic check_output();
    int n;
    if (exp_q.size() == 0) begin
        $display("Output valid with no instruction outstanding");
        abort_run();
    end
    n = exp_q.pop_front();
    check_value("o_s3_instr", o_s3_instr, {16'h00c0, n[15:0]});
    check_value("o_s3_rd", o_s3_rd, case_word(n, 5));
    check_value("o_s3_fu", o_s3_fu, case_word(n, 0));
    check_value("o_s3_trap", o_s3_trap, case_word(n, 6));
    check_value("o_s3_size", o_s3_size, n % 4);
    check_value("o_s3_opr_a", o_s3_opr_a, case_word(n, 7));
    check_value("o_s3_opr_b", o_s3_opr_b, case_word(n, 8));
    check_value("o_s3_uop", o_s3_uop, case_word(n, 9));
endtask

task automatic check_forwarding(input int n);
    logic [31:0] fu_w;
    logic [31:0] uop_w;
    fu_w  = case_word(n, 0);
    uop_w = case_word(n, 1);
    check_value("o_fwd_rd", o_fwd_rd, case_word(n, 5));
    check_value("o_fwd_load", o_fwd_load, fu_w == FU_LSU && uop_w == LSU_LOAD);
    check_value("o_fwd_csr", o_fwd_csr, fu_w == FU_CSR);
endtask

initial begin
    seed       = 83;
    i_reset    = 1'b1;
    i_flush    = 1'b0;
    i_s2_valid = 1'b0;
    i_s2_rd    = '0;
    i_s2_opr_a = '0;
    i_s2_opr_b = '0;
    i_s2_opr_c = '0;
    i_s2_uop   = '0;
    i_s2_fu    = FU_ALU;
    i_s2_trap  = 1'b0;
    i_s2_size  = '0;
    i_s2_instr = '0;
    i_s3_busy  = 1'b0;

    for (j = 0; j < MAX_CASES*CASE_WORDS; j++) begin
        case_mem[j] = {16'hffff, j[15:0]};      // Unused rows read as illegal fu
    end
    $readmemh("test/exec_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_word(num_cases, 0) <= 32'd4) begin
        num_cases++;
    end
    if (num_cases == 0) begin
        $display("No cases were read from the case file");
        abort_run();
    end

    repeat (4) @(posedge g_clk);
    @(negedge g_clk);
    i_reset = 1'b0;
    #1;
    check_value("o_s3_valid", o_s3_valid, 1'b0);
    check_value("o_s2_busy", o_s2_busy, 1'b0);

    // ----------------------------------------
    // Case stream under random writeback stall
    idx         = 0;
    waited      = 0;
    first_cycle = 1'b1;
    while (idx < num_cases) begin
        @(negedge g_clk);
        drive_case(idx);
        i_s3_busy = ($random(seed) % 2) != 0;
        #1;
        if (o_s3_valid && !i_s3_busy) begin
            check_output();                     // Leaves on the next edge
        end
        check_forwarding(idx);
        if (first_cycle && case_word(idx, 0) == FU_MUL) begin
            check_value("o_s2_busy", o_s2_busy, 1'b1); // Multiply never done at once
        end
        first_cycle = 1'b0;
        if (!o_s2_busy) begin
            check_value("o_fwd_wdata", o_fwd_wdata, expected_wdata(idx));
            exp_q.push_back(idx);               // Accepted on the next edge
            idx++;
            waited      = 0;
            first_cycle = 1'b1;
        end else begin
            waited++;
            if (waited > CASE_TIMEOUT) begin
                $display("Timed out waiting for case %0d to be accepted", idx);
                abort_run();
            end
        end
    end

    // Drain what is still in flight
    waited = 0;
    while (exp_q.size() != 0) begin
        @(negedge g_clk);
        i_s2_valid = 1'b0;
        i_s3_busy  = ($random(seed) % 2) != 0;
        #1;
        if (o_s3_valid && !i_s3_busy) begin
            check_output();
        end
        waited++;
        if (waited > CASE_TIMEOUT) begin
            $display("Timed out waiting for results to drain");
            abort_run();
        end
    end

    // ----------------------------------------
    // Flush with an item held in s3
    waited = 0;
    @(negedge g_clk);
    i_s3_busy = 1'b1;                           // Keep the item in the register
    drive_case(0);
    #1;
    while (o_s2_busy) begin
        @(negedge g_clk);
        #1;
        waited++;
        if (waited > CASE_TIMEOUT) begin
            $display("Timed out waiting for the flush case to be accepted");
            abort_run();
        end
    end
    exp_q.push_back(0);
    @(negedge g_clk);
    i_s2_valid = 1'b0;
    i_flush    = 1'b1;
    #1;
    check_value("o_s3_valid", o_s3_valid, 1'b1);
    @(negedge g_clk);
    i_flush   = 1'b0;
    i_s3_busy = 1'b0;
    #1;
    check_value("o_s3_valid", o_s3_valid, 1'b0);
    idx = exp_q.pop_back();                     // Flushed item never reaches writeback

    // Next case is the first to leave after the flush
    @(negedge g_clk);
    drive_case(1);
    #1;
    check_value("o_s3_valid", o_s3_valid, 1'b0);
    check_value("o_s2_busy", o_s2_busy, 1'b0);
    exp_q.push_back(1);
    @(negedge g_clk);
    i_s2_valid = 1'b0;
    #1;
    check_value("o_s3_valid", o_s3_valid, 1'b1);
    check_output();

    $display("Simulation PASSED");
    $finish;
end

endmodule

// ==== test/exec_cases.txt ====
// One case per line, hex words:
// fu uop opr_a opr_b opr_c rd trap exp_opr_a exp_opr_b exp_uop
// ALU
0 0 00000005 00000007 00000000 01 0 0000000c 00000000 0
0 0 ffffffff 00000002 00000000 02 0 00000001 00000000 0
0 1 00000003 00000005 00000000 03 0 fffffffe 00000000 1
0 2 f0f0f0f0 ff00ff00 00000000 04 0 0ff00ff0 00000000 2
0 3 f0f0f0f0 0f0000ff 00000000 05 0 fff0f0ff 00000000 3
0 4 f0f0f0f0 ff00ff00 00000000 06 0 f000f000 00000000 4
0 5 00000001 0000001f 00000000 07 0 80000000 00000000 5
0 5 00000003 00000024 00000000 08 0 00000030 00000000 5
0 6 80000000 00000004 00000000 09 0 08000000 00000000 6
0 7 80000000 00000004 00000000 0a 0 f8000000 00000000 7
0 8 ffffffff 00000001 00000000 0b 0 00000001 00000000 8
0 9 ffffffff 00000001 00000000 0c 0 00000000 00000000 9
// Branches and jumps
3 0 12345678 12345678 00001001 00 0 00001000 00000000 8
3 1 00000010 00000010 00002000 00 0 00002000 00000000 9
3 2 fffffff0 00000010 00000104 00 0 00000104 00000000 8
3 3 fffffff0 00000010 00000200 00 0 00000200 00000000 9
3 4 fffffff0 00000010 00000300 00 0 00000300 00000000 9
3 5 fffffff0 00000010 00000401 00 0 00000400 00000000 8
3 6 00000000 00000000 00000abd 01 0 00000abc 00000000 6
3 7 00001000 00000023 00000000 01 0 00001022 00000000 7
// Load/store and CSR
2 0 00002000 00000010 00000000 0d 0 00002010 00000000 0
2 1 00003000 fffffffc deadbeef 00 0 00002ffc deadbeef 1
4 0 00000abc 00000300 00000055 0e 0 00000abc 00000055 0
// Multiply
1 0 00001234 00005678 00000000 0f 0 06260060 00000000 0
1 1 ffffffff ffffffff 00000000 10 0 fffffffe fffffffe 1
1 0 ffffffff 00000002 00000000 11 0 fffffffe 00000001 0
1 1 80000000 00000004 00000000 12 0 00000002 00000002 1
// Traps
0 0 00000001 00000002 00000000 0b 1 00000003 0000000b 0
2 1 00000100 00000004 00001234 07 1 00000104 00000007 1

// ==== files.f ====
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_multiplier.sv
logic/exec_result_select.sv
logic/exec_pipe_reg.sv
logic/exec_stage.sv
test/tb_exec_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
# The run counts as failed if the log holds the fail message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Simulation FAILED"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_exec_stage \
    --Mdir "$BUILD_DIR" -o tb_exec_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_exec_stage_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "Testbench reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
exit 0
